//--- Makefile
.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module lsuMemTb -f filelist.f -o simLsuMem

run: compile
	./obj_dir/simLsuMem +verilator+error+limit+100 > sim.log 2>&1; cat sim.log
	! grep -q "Testbench failed" sim.log
	grep -q "Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- filelist.f
logic/lsuPkg.sv
logic/memReqIf.sv
logic/dcacheReq.sv
logic/memCtrl.sv
logic/loadFormatter.sv
logic/byteMemory.sv
logic/lsuMemTop.sv
verif/lsuMem_sva.sv
verif/lsuMemTb.sv

//--- logic/byteMemory.sv
`default_nettype none

module byteMemory #(
    parameter int ADDR_WIDTH = 10
) (
    input  logic                  clk,
    input  logic                  we,
    input  logic [ADDR_WIDTH-1:0] addr,
    input  logic [7:0]            wdata,
    output logic [7:0]            rdata
);

    localparam int DEPTH = 2 ** ADDR_WIDTH;

    logic [7:0] memArray [DEPTH];

    // Contents start at zero so that early loads read a known value.
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            memArray[i] = 8'h00;
        end
    end

    always_ff @(posedge clk) begin
        if (we) begin
            memArray[addr] <= wdata;
        end
    end

    assign rdata = memArray[addr]; // read is combinational.

endmodule

`default_nettype wire

//--- logic/dcacheReq.sv
`default_nettype none

module dcacheReq
    import lsuPkg::*;
#(
    parameter int ADDR_WIDTH = 10,
    parameter int NICK_WIDTH = 4
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  rdy,
    input  logic                  reqEn,
    input  memOp_e                reqOp,
    input  logic [ADDR_WIDTH-1:0] reqAddr,
    input  logic [DATA_WIDTH-1:0] reqData,
    input  logic [NICK_WIDTH-1:0] reqNick,
    output logic                  reqReady,
    output memOp_e                heldOp,
    output logic [NICK_WIDTH-1:0] heldNick,
    memReqIf.holder               mem
);

    logic                  occupied;
    logic                  accept;
    logic [ADDR_WIDTH-1:0] heldAddr;
    logic [DATA_WIDTH-1:0] heldData;

    assign reqReady = rdy && !occupied; // one request in flight at most.
    assign accept   = reqEn && reqReady;

    assign mem.valid = occupied; // held until the controller reports done.
    assign mem.op    = heldOp;
    assign mem.addr  = heldAddr;
    assign mem.wdata = heldData;

    always_ff @(posedge clk) begin
        if (rst) begin
            occupied <= 1'b0;
        end else if (rdy) begin
            if (mem.done) begin
                occupied <= 1'b0;
            end else if (accept) begin
                occupied <= 1'b1;
            end
        end
    end

    // the tag stays here and meets the data again at the formatter.
    always_ff @(posedge clk) begin
        if (accept) begin
            heldOp   <= reqOp;
            heldAddr <= reqAddr;
            heldData <= reqData;
            heldNick <= reqNick;
        end
    end

endmodule

`default_nettype wire

//--- logic/loadFormatter.sv
`default_nettype none

module loadFormatter
    import lsuPkg::*;
#(
    parameter int NICK_WIDTH = 4
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  rdy,
    input  logic                  done,
    input  logic [DATA_WIDTH-1:0] rdata,
    input  memOp_e                op,
    input  logic [NICK_WIDTH-1:0] nick,
    output logic                  respDone,
    output logic [DATA_WIDTH-1:0] respData,
    output logic [NICK_WIDTH-1:0] respNick
);

    logic [DATA_WIDTH-1:0] extData;

    always_comb begin
        case (op)
            OP_LB:   extData = {{(DATA_WIDTH-8){rdata[7]}}, rdata[7:0]};
            OP_LH:   extData = {{(DATA_WIDTH-16){rdata[15]}}, rdata[15:0]};
            OP_LW:   extData = rdata;
            OP_LBU:  extData = {{(DATA_WIDTH-8){1'b0}}, rdata[7:0]};
            OP_LHU:  extData = {{(DATA_WIDTH-16){1'b0}}, rdata[15:0]};
            default: extData = '0; // stores complete with no data.
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            respDone <= 1'b0;
        end else if (rdy) begin
            respDone <= done;
        end
    end

    always_ff @(posedge clk) begin
        if (rdy && done) begin
            respData <= extData;
            respNick <= nick;
        end
    end

endmodule

`default_nettype wire

//--- logic/lsuMemTop.sv
`default_nettype none

module lsuMemTop
    import lsuPkg::*;
#(
    parameter int ADDR_WIDTH = 10,
    parameter int NICK_WIDTH = 4
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  rdy,
    input  logic                  reqEn,
    input  memOp_e                reqOp,
    input  logic [ADDR_WIDTH-1:0] reqAddr,
    input  logic [DATA_WIDTH-1:0] reqData,
    input  logic [NICK_WIDTH-1:0] reqNick,
    output logic                  reqReady,
    output logic                  respDone,
    output logic [DATA_WIDTH-1:0] respData,
    output logic [NICK_WIDTH-1:0] respNick
);

    memOp_e                heldOp;
    logic [NICK_WIDTH-1:0] heldNick;
    logic                  memWe;
    logic [ADDR_WIDTH-1:0] memAddr;
    logic [7:0]            memWdata;
    logic [7:0]            memRdata;

    memReqIf #(.ADDR_WIDTH(ADDR_WIDTH)) memBus ();

    dcacheReq #(.ADDR_WIDTH(ADDR_WIDTH), .NICK_WIDTH(NICK_WIDTH)) u_dcacheReq (
        .clk      (clk),
        .rst      (rst),
        .rdy      (rdy),
        .reqEn    (reqEn),
        .reqOp    (reqOp),
        .reqAddr  (reqAddr),
        .reqData  (reqData),
        .reqNick  (reqNick),
        .reqReady (reqReady),
        .heldOp   (heldOp),
        .heldNick (heldNick),
        .mem      (memBus.holder)
    );

    memCtrl #(.ADDR_WIDTH(ADDR_WIDTH)) u_memCtrl (
        .clk      (clk),
        .rst      (rst),
        .rdy      (rdy),
        .mem      (memBus.controller),
        .memWe    (memWe),
        .memAddr  (memAddr),
        .memWdata (memWdata),
        .memRdata (memRdata)
    );

    byteMemory #(.ADDR_WIDTH(ADDR_WIDTH)) u_byteMemory (
        .clk   (clk),
        .we    (memWe),
        .addr  (memAddr),
        .wdata (memWdata),
        .rdata (memRdata)
    );

    loadFormatter #(.NICK_WIDTH(NICK_WIDTH)) u_loadFormatter (
        .clk      (clk),
        .rst      (rst),
        .rdy      (rdy),
        .done     (memBus.done),
        .rdata    (memBus.rdata),
        .op       (heldOp),
        .nick     (heldNick),
        .respDone (respDone),
        .respData (respData),
        .respNick (respNick)
    );

endmodule

`default_nettype wire

//--- logic/lsuPkg.sv
`default_nettype none

package lsuPkg;

    localparam int DATA_WIDTH = 32;

    typedef enum logic [2:0] {
        OP_LB  = 3'd0,
        OP_LH  = 3'd1,
        OP_LW  = 3'd2,
        OP_LBU = 3'd3,
        OP_LHU = 3'd4,
        OP_SB  = 3'd5,
        OP_SH  = 3'd6,
        OP_SW  = 3'd7
    } memOp_e;

    typedef enum logic [1:0] {
        CTRL_IDLE     = 2'd0,
        CTRL_TRANSFER = 2'd1,
        CTRL_FINISH   = 2'd2
    } ctrlState_e;

    function automatic logic [2:0] opBytes(memOp_e op);
        case (op)
            OP_LB, OP_LBU, OP_SB: return 3'd1;
            OP_LH, OP_LHU, OP_SH: return 3'd2;
            default: return 3'd4;
        endcase
    endfunction

    function automatic logic isStore(memOp_e op);
        return op inside {OP_SB, OP_SH, OP_SW};
    endfunction

endpackage

`default_nettype wire

//--- logic/memCtrl.sv
`default_nettype none

module memCtrl
    import lsuPkg::*;
#(
    parameter int ADDR_WIDTH = 10
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  rdy,
    memReqIf.controller           mem,
    output logic                  memWe,
    output logic [ADDR_WIDTH-1:0] memAddr,
    output logic [7:0]            memWdata,
    input  logic [7:0]            memRdata
);

    ctrlState_e            state;
    logic [1:0]            byteCnt;
    logic                  lastByte;
    logic                  start;
    logic                  doneReg;
    logic [DATA_WIDTH-1:0] rdataReg;

    assign mem.busy  = (state != CTRL_IDLE);
    assign mem.done  = doneReg;
    assign mem.rdata = rdataReg;

    assign start    = mem.valid && !mem.busy;
    assign lastByte = ({1'b0, byteCnt} == opBytes(mem.op) - 3'd1);

    assign memAddr  = mem.addr + ADDR_WIDTH'(byteCnt); // little-endian byte walk.
    assign memWdata = mem.wdata[8*byteCnt +: 8];
    assign memWe    = rdy && (state == CTRL_TRANSFER) && isStore(mem.op);

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= CTRL_IDLE;
            byteCnt <= 2'd0;
            doneReg <= 1'b0;
        end else if (rdy) begin
            case (state)
                CTRL_IDLE: begin
                    byteCnt <= 2'd0;
                    if (start) begin
                        state <= CTRL_TRANSFER;
                    end
                end
                CTRL_TRANSFER: begin
                    byteCnt <= byteCnt + 2'd1;
                    if (lastByte) begin
                        state   <= CTRL_FINISH;
                        doneReg <= 1'b1; // the last byte lands on this edge.
                    end
                end
                CTRL_FINISH: begin
                    state   <= CTRL_IDLE;
                    doneReg <= 1'b0;
                end
                default: begin
                    state   <= CTRL_IDLE;
                    doneReg <= 1'b0;
                end
            endcase
        end
    end

    // Load bytes are collected one lane per transfer cycle.
    always_ff @(posedge clk) begin
        if (rdy) begin
            if (state == CTRL_IDLE && start) begin
                rdataReg <= '0; // upper lanes stay zero for short loads.
            end else if (state == CTRL_TRANSFER && !isStore(mem.op)) begin
                rdataReg[8*byteCnt +: 8] <= memRdata;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/memReqIf.sv
`default_nettype none

interface memReqIf
    import lsuPkg::*;
#(
    parameter int ADDR_WIDTH = 10
) ();

    logic                  valid;
    memOp_e                op;
    logic [ADDR_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0] wdata;
    logic                  busy;
    logic                  done; // one cycle, with rdata complete.
    logic [DATA_WIDTH-1:0] rdata;

    modport holder (
        output valid, op, addr, wdata,
        input  busy, done, rdata
    );

    modport controller (
        input  valid, op, addr, wdata,
        output busy, done, rdata
    );

endinterface

`default_nettype wire

//--- verif/lsuMemTb.sv
`default_nettype none

module lsuMemTb
    import lsuPkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int ADDR_WIDTH = 10;
    localparam int NICK_WIDTH = 4;
    localparam int TIMEOUT    = 40; // cycles allowed for any single wait.

    logic                  clk;
    logic                  rst;
    logic                  rdy;
    logic                  reqEn;
    memOp_e                reqOp;
    logic [ADDR_WIDTH-1:0] reqAddr;
    logic [DATA_WIDTH-1:0] reqData;
    logic [NICK_WIDTH-1:0] reqNick;
    logic                  reqReady;
    logic                  respDone;
    logic [DATA_WIDTH-1:0] respData;
    logic [NICK_WIDTH-1:0] respNick;

    logic [7:0]            refMem [2**ADDR_WIDTH]; // mirrors the DUT memory.
    logic [DATA_WIDTH-1:0] expDataQ [$];
    logic [NICK_WIDTH-1:0] expNickQ [$];
    logic [31:0]           lcgState = 32'h5580;
    int                    cycle = 0;
    int                    errCount = 0;
    int                    passTests = 0;
    int                    failTests = 0;

    lsuMemTop #(.ADDR_WIDTH(ADDR_WIDTH), .NICK_WIDTH(NICK_WIDTH)) u_lsuMemTop (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    // Little-endian assembly, then sign fill for the signed short loads.
    function automatic logic [DATA_WIDTH-1:0] modelLoad(memOp_e op, logic [ADDR_WIDTH-1:0] addr);
        logic [DATA_WIDTH-1:0] value;
        int n;
        value = '0;
        n = int'(opBytes(op));
        for (int i = 0; i < n; i++) begin
            value[8*i +: 8] = refMem[ADDR_WIDTH'(addr + i)];
        end
        if ((op == OP_LB || op == OP_LH) && value[8*n-1]) begin
            value = value | ~((32'd1 << (8*n)) - 32'd1);
        end
        return value;
    endfunction

    function automatic void modelStore(memOp_e op, logic [ADDR_WIDTH-1:0] addr,
                                       logic [DATA_WIDTH-1:0] data);
        for (int i = 0; i < int'(opBytes(op)); i++) begin
            refMem[ADDR_WIDTH'(addr + i)] = data[8*i +: 8]; // address wraps like the DUT.
        end
    endfunction

    task automatic reportErr(input string msg);
        $display("ERR at %0d ns: %s", $time, msg);
        errCount++;
    endtask

    task automatic endTest(input string name, input int errsAtStart);
        if (errCount == errsAtStart) begin
            passTests++;
            $display("PASS  %s", name);
        end else begin
            failTests++;
            $display("FAIL  %s (%0d errors)", name, errCount - errsAtStart);
        end
    endtask

    // busyOffers cycles of a second request are shown while the first is in flight.
    task automatic access(input memOp_e op, input logic [ADDR_WIDTH-1:0] addr,
                          input logic [DATA_WIDTH-1:0] data, input logic [NICK_WIDTH-1:0] nick,
                          input int stallLen, input int busyOffers);
        int waited;
        int startCycle;
        int latency;
        waited = 0;
        @(negedge clk);
        while (!reqReady && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!reqReady) begin
            $display("Timeout: reqReady stayed low for %0d cycles", TIMEOUT);
            errCount++;
        end else begin
            reqEn      = 1'b1;
            reqOp      = op;
            reqAddr    = addr;
            reqData    = data;
            reqNick    = nick;
            startCycle = cycle; // accepted on the coming rising edge.
            if (op inside {OP_SB, OP_SH, OP_SW}) begin
                expDataQ.push_back('0);
                modelStore(op, addr, data);
            end else begin
                expDataQ.push_back(modelLoad(op, addr));
            end
            expNickQ.push_back(nick);
            @(negedge clk);
            for (int i = 0; i < busyOffers; i++) begin
                reqOp   = OP_SW;
                reqAddr = 'h30;
                reqData = '1;
                @(negedge clk);
            end
            reqEn = 1'b0;
            assert (!reqReady) else reportErr("reqReady high while a request is in flight");
            if (stallLen > 0) begin
                @(negedge clk);
                rdy = 1'b0;
                repeat (stallLen) @(negedge clk);
                rdy = 1'b1;
            end
            waited = 0;
            while (!respDone && waited < TIMEOUT) begin
                @(negedge clk);
                waited++;
            end
            if (!respDone) begin
                $display("Timeout: no response for %s within %0d cycles", op.name(), TIMEOUT);
                errCount++;
            end else begin
                latency = cycle - startCycle;
                assert (latency == int'(opBytes(op)) + 3 + stallLen)
                    else reportErr($sformatf("%s took %0d cycles", op.name(), latency));
                assert (respData == expDataQ[0])
                    else reportErr($sformatf("%s at %h returned %h, expected %h",
                                             op.name(), addr, respData, expDataQ[0]));
                assert (respNick == expNickQ[0])
                    else reportErr($sformatf("respNick %0d, expected %0d", respNick, expNickQ[0]));
                void'(expDataQ.pop_front());
                void'(expNickQ.pop_front());
            end
        end
    endtask

    initial begin
        int          errsAtStart;
        int          svaFails;
        logic [31:0] r;
        logic [31:0] d;
        rst     = 1'b1;
        rdy     = 1'b1;
        reqEn   = 1'b0;
        reqOp   = OP_LW;
        reqAddr = '0;
        reqData = '0;
        reqNick = '0;
        for (int i = 0; i < 2**ADDR_WIDTH; i++) begin
            refMem[i] = 8'h00;
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        errsAtStart = errCount;
        @(negedge clk);
        assert (reqReady && !respDone) else reportErr("reqReady low or respDone high after reset");
        endTest("reset state", errsAtStart);

        errsAtStart = errCount;
        access(OP_SW, 10'h010, 32'hA1B2_C3D4, 4'd1, 0, 0);
        access(OP_LW, 10'h010, '0, 4'd2, 0, 0);
        access(OP_SH, 10'h012, 32'h0000_5E6F, 4'd3, 0, 0);
        access(OP_SB, 10'h011, 32'h0000_0077, 4'd4, 0, 0);
        access(OP_LW, 10'h010, '0, 4'd5, 0, 0);
        access(OP_LH, 10'h012, '0, 4'd6, 0, 0);
        access(OP_LHU, 10'h010, '0, 4'd7, 0, 0);
        access(OP_LB, 10'h011, '0, 4'd8, 0, 0);
        access(OP_LBU, 10'h013, '0, 4'd9, 0, 0);
        endTest("store then load, all widths", errsAtStart);

        errsAtStart = errCount;
        access(OP_SB, 10'h020, 32'h0000_009C, 4'd1, 0, 0);
        access(OP_SH, 10'h022, 32'h0000_F00D, 4'd2, 0, 0);
        access(OP_LB, 10'h020, '0, 4'd3, 0, 0);
        access(OP_LBU, 10'h020, '0, 4'd4, 0, 0);
        access(OP_LH, 10'h022, '0, 4'd5, 0, 0);
        access(OP_LHU, 10'h022, '0, 4'd6, 0, 0);
        endTest("sign and zero extension", errsAtStart);

        errsAtStart = errCount;
        access(OP_SW, 10'h024, 32'h1234_5678, 4'd15, 0, 0);
        access(OP_LW, 10'h024, '0, 4'd0, 0, 0);
        access(OP_SH, 10'h026, 32'hFFFF_8001, 4'd10, 0, 0);
        access(OP_LB, 10'h026, '0, 4'd5, 0, 0);
        endTest("tag return and store response", errsAtStart);

        errsAtStart = errCount;
        access(OP_LW, 10'h010, '0, 4'd11, 0, 2);
        for (int i = 0; i < 6; i++) begin
            @(negedge clk);
            assert (!respDone) else reportErr("response for a request offered while busy");
        end
        access(OP_LW, 10'h030, '0, 4'd12, 0, 0); // the ignored store must not have landed.
        access(OP_LW, 10'h010, '0, 4'd13, 5, 0);
        access(OP_SH, 10'h014, 32'h0000_ABCD, 4'd14, 4, 0);
        access(OP_LW, 10'h014, '0, 4'd7, 0, 0);
        endTest("back-pressure and stall", errsAtStart);

        errsAtStart = errCount;
        for (int i = 0; i < 200; i++) begin
            r = nextRand();
            d = nextRand();
            access(memOp_e'(r[18:16]), {4'b0001, r[25:20]}, d, r[30:27], 0, 0);
        end
        endTest("random traffic", errsAtStart);

        svaFails = u_lsuMemTop.u_dcacheReq.holderChecks.failCount
                 + u_lsuMemTop.u_memCtrl.ctrlChecks.failCount;
        $display("%0d tests passed, %0d failed, %0d errors, %0d assertion failures",
                 passTests, failTests, errCount, svaFails);
        if (failTests == 0 && svaFails == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/lsuMem_sva.sv
`default_nettype none

module lsuMem_sva
    import lsuPkg::*;
#(
    parameter int ADDR_WIDTH = 10
) (
    input logic                  clk,
    input logic                  rst,
    input logic                  rdy,
    input logic                  reqEn,
    input logic                  reqReady,
    input logic                  valid,
    input memOp_e                op,
    input logic [ADDR_WIDTH-1:0] addr,
    input logic [DATA_WIDTH-1:0] wdata,
    input logic                  done,
    input ctrlState_e            state,
    input logic                  memWe,
    input logic [ADDR_WIDTH-1:0] memAddr
);
    timeunit 1ns;
    timeprecision 1ps;

    int failCount = 0; // assertion failures seen by this instance.

    acceptPresents: assert property (@(posedge clk) disable iff (rst)
        reqEn && reqReady |=> valid)
        else begin
            $error("accepted request was not presented to the controller");
            failCount++;
        end

    // from acceptance until the done edge the holder takes nothing new.
    busyNotReady: assert property (@(posedge clk) disable iff (rst)
        (reqEn && reqReady) || (valid && !(done && rdy)) |=> !reqReady)
        else begin
            $error("reqReady high before the held request was done");
            failCount++;
        end

    donePulse: assert property (@(posedge clk) disable iff (rst)
        done && rdy |=> !done)
        else begin
            $error("done stayed high for more than one cycle");
            failCount++;
        end

    heldStable: assert property (@(posedge clk) disable iff (rst)
        valid && !(done && rdy) |=> valid && $stable(op) && $stable(addr) && $stable(wdata))
        else begin
            $error("valid or request fields changed before done");
            failCount++;
        end

    noWriteIdle: assert property (@(posedge clk) disable iff (rst)
        memWe |-> state != CTRL_IDLE
                  && ADDR_WIDTH'(memAddr - addr) < ADDR_WIDTH'(opBytes(op)))
        else begin
            $error("memory write while idle or outside the bytes of the store");
            failCount++;
        end

endmodule

bind dcacheReq lsuMem_sva #(.ADDR_WIDTH(ADDR_WIDTH)) holderChecks (
    .clk(clk), .rst(rst), .rdy(rdy), .reqEn(reqEn), .reqReady(reqReady),
    .valid(mem.valid), .op(mem.op), .addr(mem.addr), .wdata(mem.wdata), .done(mem.done),
    .state(lsuPkg::CTRL_IDLE), .memWe(1'b0), .memAddr('0)
);

bind memCtrl lsuMem_sva #(.ADDR_WIDTH(ADDR_WIDTH)) ctrlChecks (
    .clk(clk), .rst(rst), .rdy(rdy), .reqEn(1'b0), .reqReady(1'b0),
    .valid(mem.valid), .op(mem.op), .addr(mem.addr), .wdata(mem.wdata), .done(mem.done),
    .state(state), .memWe(memWe), .memAddr(memAddr)
);

`default_nettype wire
